//--- verilog/mem_io_defines.svh
`ifndef MEM_IO_DEFINES_SVH
`define MEM_IO_DEFINES_SVH

// data bus and address space of the 8-bit core
`define MEM_ADDR_BITS 8
`define MEM_DATA_BITS 8

// output ports sit at the top of the address space
`define IO_BASE_ADDR 8'hfc
`define NUM_OUT_PORTS 4

`endif

//--- verilog/mem_io_pkg.sv
`include "mem_io_defines.svh"

package mem_io_pkg;

    // one access from the bus slave, 18 bits
    typedef struct packed {
        logic                      valid;
        logic                      we;
        logic [`MEM_ADDR_BITS-1:0] addr;
        logic [`MEM_DATA_BITS-1:0] wdata;
    } mem_req_t;

    // access to the output-port bank, 12 bits
    typedef struct packed {
        logic                               valid;
        logic                               we;
        logic [$clog2(`NUM_OUT_PORTS)-1:0]  idx;
        logic [`MEM_DATA_BITS-1:0]          data;
    } port_req_t;

    // port values plus one write strobe each, 36 bits
    typedef struct packed {
        logic [`NUM_OUT_PORTS-1:0][`MEM_DATA_BITS-1:0] value;
        logic [`NUM_OUT_PORTS-1:0]                     strobe;
    } out_ports_t;

endpackage

//--- verilog/data_ram.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module data_ram (
    input  logic                      clk,
    input  logic                      en,
    input  logic                      we,
    input  logic [`MEM_ADDR_BITS-1:0] addr,
    input  logic [`MEM_DATA_BITS-1:0] wdata,
    output logic [`MEM_DATA_BITS-1:0] rdata
);

    localparam int DEPTH = 2 ** `MEM_ADDR_BITS;

    logic [`MEM_DATA_BITS-1:0] mem [DEPTH];

    // single port, write or registered read
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr]; // holds until next read
            end
        end
    end

endmodule

//--- verilog/out_port_bank.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module out_port_bank (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_io_pkg::port_req_t     port_req,
    output logic [`MEM_DATA_BITS-1:0] port_rdata,
    output mem_io_pkg::out_ports_t    ports
);
    import mem_io_pkg::*;

    out_ports_t ports_q;

    assign ports = ports_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ports_q.value  <= '0;
            ports_q.strobe <= '0;
        end else begin
            ports_q.strobe <= '0; // strobes last one cycle
            if (port_req.valid && port_req.we) begin
                ports_q.value[port_req.idx]  <= port_req.data;
                ports_q.strobe[port_req.idx] <= 1'b1;
            end
        end
    end

    // read back, same latency as the ram
    always_ff @(posedge clk) begin
        if (port_req.valid && !port_req.we) begin
            port_rdata <= ports_q.value[port_req.idx];
        end
    end

endmodule

//--- verilog/memory_io_mux.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module memory_io_mux (
    input  logic                      clk,
    input  logic                      reset,
    input  mem_io_pkg::mem_req_t      req,
    output logic [`MEM_DATA_BITS-1:0] rd_data,

    output logic                      ram_en,
    output logic                      ram_we,
    output logic [`MEM_ADDR_BITS-1:0] ram_addr,
    output logic [`MEM_DATA_BITS-1:0] ram_wdata,
    input  logic [`MEM_DATA_BITS-1:0] ram_rdata,

    output mem_io_pkg::port_req_t     port_req,
    input  logic [`MEM_DATA_BITS-1:0] port_rdata
);
    import mem_io_pkg::*;

    localparam int SEL_BITS = $clog2(`NUM_OUT_PORTS);
    localparam logic [`MEM_ADDR_BITS-1:0] IO_BASE = `IO_BASE_ADDR;

    logic is_port;
    logic sel_port_q; // target of the last request

    // fc..ff share the upper address bits
    assign is_port = (req.addr[`MEM_ADDR_BITS-1:SEL_BITS]
                      == IO_BASE[`MEM_ADDR_BITS-1:SEL_BITS]);

    // ram side, a port access never enables the ram
    assign ram_en    = req.valid && !is_port;
    assign ram_we    = req.we;
    assign ram_addr  = req.addr;
    assign ram_wdata = req.wdata;

    always_comb begin
        port_req = port_req_t'{
            valid: req.valid && is_port,
            we:    req.we,
            idx:   req.addr[SEL_BITS-1:0],
            data:  req.wdata
        };
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sel_port_q <= 1'b0;
        end else if (req.valid) begin
            sel_port_q <= is_port;
        end
    end

    // both targets return data one cycle after the request
    assign rd_data = sel_port_q ? port_rdata : ram_rdata;

endmodule

//--- verilog/wb_mem_slave.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module wb_mem_slave (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`MEM_ADDR_BITS-1:0] adr,
    input  logic [`MEM_DATA_BITS-1:0] dat_w,
    output logic [`MEM_DATA_BITS-1:0] dat_r,
    output logic                      ack,
    output mem_io_pkg::mem_req_t      req,
    input  logic [`MEM_DATA_BITS-1:0] rd_data
);
    import mem_io_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ACK
    } state_t;

    localparam int WAIT_CYCLES = 2; // request edge to ack

    state_t   state;
    logic [1:0] wait_cnt;
    mem_req_t req_q;

    assign req = req_q;
    assign ack = (state == S_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= S_IDLE;
            wait_cnt    <= '0;
            req_q.valid <= 1'b0;
        end else begin
            req_q.valid <= 1'b0; // one cycle pulse per bus cycle
            case (state)
                S_IDLE: begin
                    if (cyc && stb) begin
                        req_q.valid <= 1'b1;
                        req_q.we    <= we;
                        req_q.addr  <= adr;
                        req_q.wdata <= dat_w;
                        wait_cnt    <= '0;
                        state       <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (wait_cnt == 2'(WAIT_CYCLES - 1)) begin
                        dat_r <= rd_data; // read data is valid one cycle after req
                        state <= S_ACK;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                S_ACK: begin
                    // master still holds stb on this edge, ignore it
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/mem_io_top.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module mem_io_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [`MEM_ADDR_BITS-1:0] adr,
    input  logic [`MEM_DATA_BITS-1:0] dat_w,
    output logic [`MEM_DATA_BITS-1:0] dat_r,
    output logic                      ack,
    output mem_io_pkg::out_ports_t    ports
);
    import mem_io_pkg::*;

    mem_req_t  req;
    port_req_t port_req;

    logic [`MEM_DATA_BITS-1:0] rd_data;
    logic [`MEM_DATA_BITS-1:0] port_rdata;

    logic                      ram_en;
    logic                      ram_we;
    logic [`MEM_ADDR_BITS-1:0] ram_addr;
    logic [`MEM_DATA_BITS-1:0] ram_wdata;
    logic [`MEM_DATA_BITS-1:0] ram_rdata;

    wb_mem_slave u_slave (
        .clk     (clk),
        .reset   (reset),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .dat_w   (dat_w),
        .dat_r   (dat_r),
        .ack     (ack),
        .req     (req),
        .rd_data (rd_data)
    );

    memory_io_mux u_mux (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .rd_data    (rd_data),
        .ram_en     (ram_en),
        .ram_we     (ram_we),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .port_req   (port_req),
        .port_rdata (port_rdata)
    );

    data_ram u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .addr  (ram_addr),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    out_port_bank u_ports (
        .clk        (clk),
        .reset      (reset),
        .port_req   (port_req),
        .port_rdata (port_rdata),
        .ports      (ports)
    );

endmodule

//--- sim/mem_io_checker.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module mem_io_checker (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic                                          cyc,
    input  logic                                          stb,
    input  logic                                          we,
    input  logic [`MEM_ADDR_BITS-1:0]                     adr,
    input  logic [`MEM_DATA_BITS-1:0]                     dat_r,
    input  logic                                          ack,
    input  mem_io_pkg::out_ports_t                        ports,
    input  logic [8*16-1:0]                               test_name,
    input  logic [`MEM_DATA_BITS-1:0]                     exp_data,
    input  logic [`NUM_OUT_PORTS-1:0]                     exp_strobe,
    input  logic [`NUM_OUT_PORTS-1:0][`MEM_DATA_BITS-1:0] exp_values,
    output int                                            checks,
    output int                                            errors
);
    import mem_io_pkg::*;

    logic busy;
    int   phase; // negedges since stb was first seen

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    // sampled on the falling edge, away from the DUT's updates
    always @(negedge clk) begin
        logic [`NUM_OUT_PORTS-1:0] strobe_exp;
        if (reset) begin
            busy   = 1'b0;
            phase  = 0;
            checks = 0;
            errors = 0;
        end else begin
            if (busy) begin
                phase = phase + 1;
            end else if (cyc && stb) begin
                busy  = 1'b1;
                phase = 0;
            end

            // strobe lives in the cycle between request and ack
            strobe_exp = (busy && phase == 2) ? exp_strobe : '0;
            if (strobe_exp != '0 && ports.strobe == '0) begin
                checks++;
                errors++;
                $display("port write strobe missing in test %s", test_name);
            end else begin
                check_value("strobe", 32'(strobe_exp), 32'(ports.strobe));
            end

            if (busy && phase == 3) begin
                busy = 1'b0;
                checks++;
                if (!ack) begin
                    errors++;
                    $display("no ack two cycles after stb in test %s", test_name);
                end else begin
                    if (!we) begin
                        check_value($sformatf("read %02h", adr), 32'(exp_data), 32'(dat_r));
                    end
                    check_value("port values", exp_values, ports.value);
                end
            end else if (ack) begin
                errors++;
                $display("ack high outside its one-cycle slot in test %s", test_name);
            end
        end
    end

endmodule

//--- sim/tb_mem_io.sv
`timescale 1ns/1ps
`include "mem_io_defines.svh"

module tb_mem_io;
    import mem_io_pkg::*;

    logic                      clk;
    logic                      reset;
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`MEM_ADDR_BITS-1:0] adr;
    logic [`MEM_DATA_BITS-1:0] dat_w;
    logic [`MEM_DATA_BITS-1:0] dat_r;
    logic                      ack;
    out_ports_t                ports;

    logic [8*16-1:0]           test_name;
    logic [`MEM_DATA_BITS-1:0] exp_data;
    logic [`NUM_OUT_PORTS-1:0] exp_strobe;
    int                        checks;
    int                        errors;
    int                        timeouts;
    int                        tests;
    int                        errors_before;
    int                        checks_before;

    // reference model, ram words and port values
    logic [`MEM_DATA_BITS-1:0]                     mem_model [2**`MEM_ADDR_BITS];
    logic [2**`MEM_ADDR_BITS-1:0]                  written;
    logic [`NUM_OUT_PORTS-1:0][`MEM_DATA_BITS-1:0] port_model;

    mem_io_top uut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack),
        .ports (ports)
    );

    mem_io_checker chk (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .dat_r      (dat_r),
        .ack        (ack),
        .ports      (ports),
        .test_name  (test_name),
        .exp_data   (exp_data),
        .exp_strobe (exp_strobe),
        .exp_values (port_model),
        .checks     (checks),
        .errors     (errors)
    );

    always #50 clk = ~clk;

    function automatic logic [`MEM_DATA_BITS-1:0] expected_read(
        input logic [`MEM_ADDR_BITS-1:0] a);
        if (a >= `IO_BASE_ADDR) begin
            return port_model[a[1:0]]; // low bits pick the port
        end
        return mem_model[a];
    endfunction

    task automatic model_write(input logic [`MEM_ADDR_BITS-1:0] a,
                               input logic [`MEM_DATA_BITS-1:0] d);
        if (a >= `IO_BASE_ADDR) begin
            port_model[a[1:0]] = d;
        end else begin
            mem_model[a] = d;
            written[a]   = 1'b1;
        end
    endtask

    // one Wishbone classic cycle, called 1 ns after a rising edge
    task automatic bus_cycle(input logic write, input logic [`MEM_ADDR_BITS-1:0] addr,
                             input logic [`MEM_DATA_BITS-1:0] data);
        int waited;
        exp_strobe = '0;
        if (write && addr >= `IO_BASE_ADDR) begin
            exp_strobe[addr[1:0]] = 1'b1;
        end
        if (write) begin
            model_write(addr, data);
        end
        exp_data = expected_read(addr);
        cyc      = 1'b1;
        stb      = 1'b1;
        we       = write;
        adr      = addr;
        dat_w    = data;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 20);
        if (!ack) begin
            timeouts++;
            $display("no ack within 20 cycles for address %02h in test %s", addr, test_name);
        end
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name,
                 checks - checks_before, errors + timeouts - errors_before);
        checks_before = checks;
        errors_before = errors + timeouts;
        tests++;
    endtask

    initial begin
        logic [`MEM_ADDR_BITS-1:0] a;
        int gap;
        void'($urandom(32'h9bf26977));
        clk        = 1'b0;
        reset      = 1'b1;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        dat_w      = '0;
        test_name  = '0;
        exp_data   = '0;
        exp_strobe = '0;
        port_model = '0;
        written    = '0;
        timeouts   = 0;
        tests      = 0;
        errors_before = 0;
        checks_before = 0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        test_name = "after_reset";
        for (int i = 0; i < 4; i++) begin
            bus_cycle(1'b0, 8'hfc + 8'(i), 8'h00);
        end
        end_test();

        test_name = "ram_random";
        for (int i = 0; i < 200; i++) begin
            a = 8'($urandom_range(0, 251));
            if (!written[a] || $urandom_range(0, 1) == 0) begin
                bus_cycle(1'b1, a, 8'($urandom));
            end else begin
                bus_cycle(1'b0, a, 8'h00);
            end
        end
        end_test();

        test_name = "port_write";
        for (int i = 0; i < 4; i++) begin
            bus_cycle(1'b1, 8'hfc + 8'(i), 8'($urandom));
        end
        end_test();

        test_name = "port_vs_ram";
        for (int i = 0; i < 4; i++) begin
            bus_cycle(1'b1, 8'hfc + 8'(i), 8'($urandom));
        end
        for (int i = 0; i < 252; i++) begin
            if (written[8'(i)]) begin
                bus_cycle(1'b0, 8'(i), 8'h00);
            end
        end
        end_test();

        test_name = "port_readback";
        for (int i = 0; i < 4; i++) begin
            bus_cycle(1'b1, 8'hf8 + 8'(i), 8'($urandom)); // same low bits as the port
            bus_cycle(1'b1, 8'($urandom_range(0, 251)), 8'($urandom));
            bus_cycle(1'b0, 8'hfc + 8'(i), 8'h00);
        end
        end_test();

        test_name = "ack_timing";
        for (int i = 0; i < 12; i++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            a = 8'($urandom);
            bus_cycle(1'b1, a, 8'($urandom));
            bus_cycle(1'b0, a, 8'h00);
        end
        end_test();

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors + timeouts);
        if (errors + timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+verilog
verilog/mem_io_pkg.sv
verilog/data_ram.sv
verilog/out_port_bank.sv
verilog/memory_io_mux.sv
verilog/wb_mem_slave.sv
verilog/mem_io_top.sv
sim/mem_io_checker.sv
sim/tb_mem_io.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --top-module tb_mem_io -f files.f -o sim_mem_io \
    && ./obj_dir/sim_mem_io | tee /dev/stderr | grep -q "Finished with no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
